/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = cache_read_arbiter_tb
FILELIST = cache_read_arbiter.f

BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = Something failed

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	if [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

/* cache_read_arbiter.f */
verilog/cache_mem_pkg.sv
verilog/icache_miss_port.sv
verilog/read_req_arbiter.sv
verilog/read_resp_demux.sv
verilog/cache_read_arbiter.sv
verif/cache_read_arbiter_tb.sv

/* verif/cache_read_arbiter_tb.sv */
// Testbench with clock, reset, memory model, stimulus, reference beats, response checks and report
`timescale 1ns/1ns

module cache_read_arbiter_tb import cache_mem_pkg::*; ();

  localparam mem_id_t IC_ID   = 4'd1;
  localparam mem_id_t UC_ID   = 4'd2;
  localparam int      TIMEOUT = 400;
  // Beat sizes as log2 of bytes, icache lines use 8 byte beats
  localparam mem_size_t IC_SIZE = 3'd3;
  localparam mem_size_t DC_SIZE = 3'd3;
  localparam mem_size_t UC_SIZE = 3'd2;

  typedef struct packed {
    mem_data_t data;
    mem_id_t   id;
    logic      last;
  } beat_t;

  logic          clk_i;
  logic          rst_n_i;
  logic          icache_miss_valid_i;
  logic          icache_miss_ready_o;
  icache_paddr_t icache_miss_paddr_i;
  mem_id_t       icache_miss_id_i;
  logic          icache_miss_resp_valid_o;
  icache_line_t  icache_miss_resp_data_o;
  logic          dcache_miss_valid_i;
  logic          dcache_miss_ready_o;
  mem_addr_t     dcache_miss_addr_i;
  mem_len_t      dcache_miss_len_i;
  mem_size_t     dcache_miss_size_i;
  mem_id_t       dcache_miss_id_i;
  logic          dcache_miss_resp_valid_o;
  logic          dcache_miss_resp_ready_i;
  mem_data_t     dcache_miss_resp_data_o;
  mem_id_t       dcache_miss_resp_id_o;
  logic          dcache_miss_resp_last_o;
  logic          dcache_uc_read_valid_i;
  logic          dcache_uc_read_ready_o;
  mem_addr_t     dcache_uc_read_addr_i;
  mem_len_t      dcache_uc_read_len_i;
  mem_size_t     dcache_uc_read_size_i;
  mem_id_t       dcache_uc_read_id_i;
  logic          dcache_uc_read_resp_valid_o;
  logic          dcache_uc_read_resp_ready_i;
  mem_data_t     dcache_uc_read_resp_data_o;
  mem_id_t       dcache_uc_read_resp_id_o;
  logic          dcache_uc_read_resp_last_o;
  logic          mem_req_valid_o;
  logic          mem_req_ready_i;
  mem_addr_t     mem_req_addr_o;
  mem_len_t      mem_req_len_o;
  mem_size_t     mem_req_size_o;
  mem_id_t       mem_req_id_o;
  logic          mem_resp_valid_i;
  logic          mem_resp_ready_o;
  mem_data_t     mem_resp_data_i;
  mem_id_t       mem_resp_id_i;
  logic          mem_resp_last_i;

  // Expected results per port, in request order
  mem_addr_t   ic_exp[$];
  beat_t       dc_exp[$];
  beat_t       uc_exp[$];
  // Memory model state
  mem_addr_t   mq_addr[$];
  mem_len_t    mq_len[$];
  mem_id_t     mq_id[$];
  mem_id_t     req_log[$];
  int          beat_idx;
  logic        burst_gap;
  logic        resp_fire;
  logic [31:0] lfsr_state;
  // Monitor state
  logic        line_due;
  logic        dc_held;
  beat_t       dc_seen;
  beat_t       exp_beat;
  mem_addr_t   line_addr;
  port_idx_t   route;
  logic        exp_ready;
  int          value_errors = 0;
  int          other_errors = 0;

  cache_read_arbiter UUT (
    .clk_i                       (clk_i),
    .rst_n_i                     (rst_n_i),
    .icache_miss_valid_i         (icache_miss_valid_i),
    .icache_miss_ready_o         (icache_miss_ready_o),
    .icache_miss_paddr_i         (icache_miss_paddr_i),
    .icache_miss_id_i            (icache_miss_id_i),
    .icache_miss_resp_valid_o    (icache_miss_resp_valid_o),
    .icache_miss_resp_data_o     (icache_miss_resp_data_o),
    .dcache_miss_valid_i         (dcache_miss_valid_i),
    .dcache_miss_ready_o         (dcache_miss_ready_o),
    .dcache_miss_addr_i          (dcache_miss_addr_i),
    .dcache_miss_len_i           (dcache_miss_len_i),
    .dcache_miss_size_i          (dcache_miss_size_i),
    .dcache_miss_id_i            (dcache_miss_id_i),
    .dcache_miss_resp_valid_o    (dcache_miss_resp_valid_o),
    .dcache_miss_resp_ready_i    (dcache_miss_resp_ready_i),
    .dcache_miss_resp_data_o     (dcache_miss_resp_data_o),
    .dcache_miss_resp_id_o       (dcache_miss_resp_id_o),
    .dcache_miss_resp_last_o     (dcache_miss_resp_last_o),
    .dcache_uc_read_valid_i      (dcache_uc_read_valid_i),
    .dcache_uc_read_ready_o      (dcache_uc_read_ready_o),
    .dcache_uc_read_addr_i       (dcache_uc_read_addr_i),
    .dcache_uc_read_len_i        (dcache_uc_read_len_i),
    .dcache_uc_read_size_i       (dcache_uc_read_size_i),
    .dcache_uc_read_id_i         (dcache_uc_read_id_i),
    .dcache_uc_read_resp_valid_o (dcache_uc_read_resp_valid_o),
    .dcache_uc_read_resp_ready_i (dcache_uc_read_resp_ready_i),
    .dcache_uc_read_resp_data_o  (dcache_uc_read_resp_data_o),
    .dcache_uc_read_resp_id_o    (dcache_uc_read_resp_id_o),
    .dcache_uc_read_resp_last_o  (dcache_uc_read_resp_last_o),
    .mem_req_valid_o             (mem_req_valid_o),
    .mem_req_ready_i             (mem_req_ready_i),
    .mem_req_addr_o              (mem_req_addr_o),
    .mem_req_len_o               (mem_req_len_o),
    .mem_req_size_o              (mem_req_size_o),
    .mem_req_id_o                (mem_req_id_o),
    .mem_resp_valid_i            (mem_resp_valid_i),
    .mem_resp_ready_o            (mem_resp_ready_o),
    .mem_resp_data_i             (mem_resp_data_i),
    .mem_resp_id_i               (mem_resp_id_i),
    .mem_resp_last_i             (mem_resp_last_i)
  );

  always #5 clk_i = ~clk_i;

  // Galois LFSR, one step per bit
  function automatic logic take_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
    return b;
  endfunction

  // Beat k of a burst at addr
  function automatic mem_data_t ref_beat(input mem_addr_t addr, input int k);
    mem_addr_t upper;
    upper = addr + mem_addr_t'(8 * k);
    return {upper, ~upper};
  endfunction

  function automatic port_idx_t route_of(input mem_id_t id);
    if (id == IC_ID) begin
      return PORT_ICACHE;
    end else if (id == UC_ID) begin
      return PORT_UNCACHED;
    end
    return PORT_DCACHE;
  endfunction

  // Beat size that the requester behind an id asks for
  function automatic mem_size_t size_of(input mem_id_t id);
    case (route_of(id))
      PORT_ICACHE:   return IC_SIZE;
      PORT_UNCACHED: return UC_SIZE;
      default:       return DC_SIZE;
    endcase
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_id(input string name, input mem_id_t got, input mem_id_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_size(input string name, input mem_size_t got, input mem_size_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input mem_data_t got, input mem_data_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_line(input string name, input icache_line_t got,
                            input icache_line_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic note_failure(input string what);
    other_errors++;
    $display("Failure at %0t ns: %s", $time, what);
  endtask

  task automatic finish_run();
    $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  task automatic abort_run(input string what);
    note_failure(what);
    finish_run();
  endtask

  // Holds the miss until the slot takes it
  task automatic issue_icache(input icache_paddr_t paddr);
    int cycles;
    cycles = 0;
    icache_miss_valid_i = 1'b1;
    icache_miss_paddr_i = paddr;
    do begin
      @(posedge clk_i);
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("icache miss request was never accepted");
      end
    end while (!icache_miss_ready_o);
    ic_exp.push_back(mem_addr_t'(paddr));
    #1;
    icache_miss_valid_i = 1'b0;
  endtask

  task automatic issue_read(input port_idx_t port, input mem_addr_t addr, input mem_len_t len,
                            input mem_id_t id);
    int    cycles;
    beat_t beat;
    cycles = 0;
    if (port == PORT_DCACHE) begin
      dcache_miss_valid_i = 1'b1;
      dcache_miss_addr_i  = addr;
      dcache_miss_len_i   = len;
      dcache_miss_id_i    = id;
    end else begin
      dcache_uc_read_valid_i = 1'b1;
      dcache_uc_read_addr_i  = addr;
      dcache_uc_read_len_i   = len;
    end
    do begin
      @(posedge clk_i);
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("read request was never accepted by the arbiter");
      end
    end while (port == PORT_DCACHE ? !dcache_miss_ready_o : !dcache_uc_read_ready_o);
    for (int k = 0; k <= int'(len); k++) begin
      beat.data = ref_beat(addr, k);
      beat.id   = id;
      beat.last = (k == int'(len));
      if (port == PORT_DCACHE) begin
        dc_exp.push_back(beat);
      end else begin
        uc_exp.push_back(beat);
      end
    end
    #1;
    dcache_miss_valid_i    = (port == PORT_DCACHE) ? 1'b0 : dcache_miss_valid_i;
    dcache_uc_read_valid_i = (port == PORT_UNCACHED) ? 1'b0 : dcache_uc_read_valid_i;
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk_i);
      #1;
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("outstanding responses never arrived");
      end
    end while (ic_exp.size() != 0 || dc_exp.size() != 0 || uc_exp.size() != 0);
  endtask

  task automatic wait_slot_busy();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk_i);
      #1;
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("icache slot never filled");
      end
    end while (icache_miss_ready_o);
  endtask

  task automatic wait_dcache_valid();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("no dcache response appeared");
      end
    end while (!dcache_miss_resp_valid_o);
  endtask

  // Memory model, in-order bursts with random gaps
  initial begin
    mem_req_ready_i  = 1'b0;
    mem_resp_valid_i = 1'b0;
    mem_resp_data_i  = '0;
    mem_resp_id_i    = '0;
    mem_resp_last_i  = 1'b0;
    lfsr_state       = 32'h04ec_e835;
    beat_idx         = 0;
    burst_gap        = 1'b0;
    forever begin
      @(posedge clk_i);
      if (rst_n_i) begin
        if (mem_req_valid_o && mem_req_ready_i) begin
          check_size("mem_req_size_o", mem_req_size_o, size_of(mem_req_id_o));
          mq_addr.push_back(mem_req_addr_o);
          mq_len.push_back(mem_req_len_o);
          mq_id.push_back(mem_req_id_o);
          req_log.push_back(mem_req_id_o);
        end
        resp_fire = mem_resp_valid_i && mem_resp_ready_o;
        if (resp_fire && beat_idx == int'(mq_len[0])) begin
          void'(mq_addr.pop_front());
          void'(mq_len.pop_front());
          void'(mq_id.pop_front());
          beat_idx  = 0;
          burst_gap = 1'b1;
        end else if (resp_fire) begin
          beat_idx++;
        end
        #1;
        mem_req_ready_i = take_bit() | take_bit();
        // A stalled beat holds its payload
        if (!mem_resp_valid_i || resp_fire) begin
          mem_resp_valid_i = 1'b0;
          if (!burst_gap && mq_addr.size() > 0 && take_bit()) begin
            mem_resp_valid_i = 1'b1;
            mem_resp_data_i  = ref_beat(mq_addr[0], beat_idx);
            mem_resp_id_i    = mq_id[0];
            mem_resp_last_i  = (beat_idx == int'(mq_len[0]));
          end
          burst_gap = 1'b0;
        end
      end
    end
  end

  // Routing, line pulse, stall and per-port beat checks
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      line_due = 1'b0;
      dc_held  = 1'b0;
    end else begin
      route = route_of(mem_resp_id_i);
      check_bit("dcache_miss_resp_valid_o", dcache_miss_resp_valid_o,
                mem_resp_valid_i && route == PORT_DCACHE);
      check_bit("dcache_uc_read_resp_valid_o", dcache_uc_read_resp_valid_o,
                mem_resp_valid_i && route == PORT_UNCACHED);
      if (mem_resp_valid_i) begin
        exp_ready = (route == PORT_ICACHE) ? 1'b1 :
                    (route == PORT_DCACHE) ? dcache_miss_resp_ready_i :
                    dcache_uc_read_resp_ready_i;
        check_bit("mem_resp_ready_o", mem_resp_ready_o, exp_ready);
      end
      if (dc_held) begin
        check_bit("dcache_miss_resp_valid_o", dcache_miss_resp_valid_o, 1'b1);
        check_data("dcache_miss_resp_data_o", dcache_miss_resp_data_o, dc_seen.data);
        check_id("dcache_miss_resp_id_o", dcache_miss_resp_id_o, dc_seen.id);
        check_bit("dcache_miss_resp_last_o", dcache_miss_resp_last_o, dc_seen.last);
      end
      dc_held      = dcache_miss_resp_valid_o && !dcache_miss_resp_ready_i;
      dc_seen.data = dcache_miss_resp_data_o;
      dc_seen.id   = dcache_miss_resp_id_o;
      dc_seen.last = dcache_miss_resp_last_o;
      // Line pulse one cycle after the last icache beat
      check_bit("icache_miss_resp_valid_o", icache_miss_resp_valid_o, line_due);
      if (icache_miss_resp_valid_o && ic_exp.size() == 0) begin
        note_failure("icache line arrived with no miss outstanding");
      end else if (icache_miss_resp_valid_o) begin
        line_addr = ic_exp.pop_front();
        check_line("icache_miss_resp_data_o", icache_miss_resp_data_o,
                   {ref_beat(line_addr, 1), ref_beat(line_addr, 0)});
      end
      line_due = mem_resp_valid_i && route == PORT_ICACHE && mem_resp_last_i;
      if (dcache_miss_resp_valid_o && dcache_miss_resp_ready_i) begin
        if (dc_exp.size() == 0) begin
          note_failure("dcache beat arrived with no request outstanding");
        end else begin
          exp_beat = dc_exp.pop_front();
          check_data("dcache_miss_resp_data_o", dcache_miss_resp_data_o, exp_beat.data);
          check_id("dcache_miss_resp_id_o", dcache_miss_resp_id_o, exp_beat.id);
          check_bit("dcache_miss_resp_last_o", dcache_miss_resp_last_o, exp_beat.last);
        end
      end
      if (dcache_uc_read_resp_valid_o && dcache_uc_read_resp_ready_i) begin
        if (uc_exp.size() == 0) begin
          note_failure("uncached beat arrived with no request outstanding");
        end else begin
          exp_beat = uc_exp.pop_front();
          check_data("dcache_uc_read_resp_data_o", dcache_uc_read_resp_data_o, exp_beat.data);
          check_id("dcache_uc_read_resp_id_o", dcache_uc_read_resp_id_o, exp_beat.id);
          check_bit("dcache_uc_read_resp_last_o", dcache_uc_read_resp_last_o, exp_beat.last);
        end
      end
    end
  end

  initial begin
    mem_id_t exp_id;
    clk_i                       = 1'b0;
    rst_n_i                     = 1'b0;
    icache_miss_valid_i         = 1'b0;
    icache_miss_paddr_i         = '0;
    icache_miss_id_i            = IC_ID;
    dcache_miss_valid_i         = 1'b0;
    dcache_miss_addr_i          = '0;
    dcache_miss_len_i           = '0;
    dcache_miss_size_i          = DC_SIZE;
    dcache_miss_id_i            = 4'd4;
    dcache_miss_resp_ready_i    = 1'b1;
    dcache_uc_read_valid_i      = 1'b0;
    dcache_uc_read_addr_i       = '0;
    dcache_uc_read_len_i        = '0;
    dcache_uc_read_size_i       = UC_SIZE;
    dcache_uc_read_id_i         = UC_ID;
    dcache_uc_read_resp_ready_i = 1'b1;
    repeat (16) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // Idle state out of reset
    @(posedge clk_i);
    check_bit("mem_req_valid_o", mem_req_valid_o, 1'b0);
    check_bit("icache_miss_resp_valid_o", icache_miss_resp_valid_o, 1'b0);
    check_bit("dcache_miss_resp_valid_o", dcache_miss_resp_valid_o, 1'b0);
    check_bit("dcache_uc_read_resp_valid_o", dcache_uc_read_resp_valid_o, 1'b0);
    check_bit("icache_miss_ready_o", icache_miss_ready_o, 1'b1);
    #1;

    // Top paddr bit set so the address must be zero extended
    issue_icache(26'h212_3440);
    wait_drained();
    issue_read(PORT_DCACHE, 32'h8000_1000, 8'd3, 4'd4);
    wait_drained();
    issue_read(PORT_UNCACHED, 32'h4000_0020, 8'd0, UC_ID);
    wait_drained();

    // All three ports busy, data cache streams start once the slot holds a miss
    req_log.delete();
    fork
      for (int k = 0; k < 3; k++) begin
        issue_icache(icache_paddr_t'(26'h000_0100 + 26'h40 * k));
      end
      begin
        wait_slot_busy();
        fork
          for (int k = 0; k < 3; k++) begin
            issue_read(PORT_DCACHE, 32'h0001_0000 + 32'h100 * k, mem_len_t'(k),
                       mem_id_t'(5 + k));
          end
          for (int k = 0; k < 3; k++) begin
            issue_read(PORT_UNCACHED, 32'h2000_0000 + 32'h10 * k, mem_len_t'(k % 2), UC_ID);
          end
        join
      end
    join
    wait_drained();
    if (req_log.size() != 9) begin
      note_failure("memory bus did not carry nine requests");
    end
    for (int k = 0; k < req_log.size(); k++) begin
      case (k % 3)
        0:       exp_id = IC_ID;
        1:       exp_id = mem_id_t'(5 + k / 3);
        default: exp_id = UC_ID;
      endcase
      check_id("mem_req_id_o", req_log[k], exp_id);
    end

    // Dcache response back-pressure
    dcache_miss_resp_ready_i = 1'b0;
    issue_read(PORT_DCACHE, 32'h0003_0000, 8'd3, 4'd9);
    wait_dcache_valid();
    repeat (4) @(posedge clk_i);
    #1;
    dcache_miss_resp_ready_i = 1'b1;
    wait_drained();

    finish_run();
  end

endmodule

/* verilog/cache_mem_pkg.sv */
// Bus widths, fixed instruction cache request fields, read port indices and bus types
package cache_mem_pkg;

  // Memory bus widths
  localparam int MEM_ADDR_W     = 32;
  localparam int ICACHE_PADDR_W = 26;
  localparam int MEM_DATA_W     = 64;
  localparam int ICACHE_LINE_W  = 128;
  localparam int MEM_ID_W       = 4;
  localparam int MEM_LEN_W      = 8;
  localparam int MEM_SIZE_W     = 3;

  // Instruction cache line refill geometry
  localparam int ICACHE_BEATS = ICACHE_LINE_W / MEM_DATA_W;

  typedef logic [MEM_ADDR_W-1:0]     mem_addr_t;
  typedef logic [ICACHE_PADDR_W-1:0] icache_paddr_t;
  typedef logic [MEM_DATA_W-1:0]     mem_data_t;
  typedef logic [MEM_ID_W-1:0]       mem_id_t;
  typedef logic [MEM_LEN_W-1:0]      mem_len_t;
  typedef logic [MEM_SIZE_W-1:0]     mem_size_t;
  typedef logic [ICACHE_LINE_W-1:0]  icache_line_t;
  typedef logic [1:0]                port_idx_t;

  // Burst length is beats minus one
  localparam mem_len_t  ICACHE_REQ_LEN  = mem_len_t'(ICACHE_BEATS - 1);
  // log2 of the beat size in bytes
  localparam mem_size_t ICACHE_REQ_SIZE = mem_size_t'($clog2(MEM_DATA_W / 8));

  // Read requesters sharing the memory bus
  localparam int        N_READ_PORTS  = 3;
  localparam port_idx_t PORT_ICACHE   = 2'd0;
  localparam port_idx_t PORT_DCACHE   = 2'd1;
  localparam port_idx_t PORT_UNCACHED = 2'd2;

endpackage

/* verilog/cache_read_arbiter.sv */
// Read-side cache miss arbiter top with icache port, request arbiter and response demux
`timescale 1ns/1ns

module cache_read_arbiter import cache_mem_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_n_i,
  // Instruction cache miss
  input  logic          icache_miss_valid_i,
  output logic          icache_miss_ready_o,
  input  icache_paddr_t icache_miss_paddr_i,
  input  mem_id_t       icache_miss_id_i,
  output logic          icache_miss_resp_valid_o,
  output icache_line_t  icache_miss_resp_data_o,
  // Data cache miss
  input  logic          dcache_miss_valid_i,
  output logic          dcache_miss_ready_o,
  input  mem_addr_t     dcache_miss_addr_i,
  input  mem_len_t      dcache_miss_len_i,
  input  mem_size_t     dcache_miss_size_i,
  input  mem_id_t       dcache_miss_id_i,
  output logic          dcache_miss_resp_valid_o,
  input  logic          dcache_miss_resp_ready_i,
  output mem_data_t     dcache_miss_resp_data_o,
  output mem_id_t       dcache_miss_resp_id_o,
  output logic          dcache_miss_resp_last_o,
  // Data cache uncached read
  input  logic          dcache_uc_read_valid_i,
  output logic          dcache_uc_read_ready_o,
  input  mem_addr_t     dcache_uc_read_addr_i,
  input  mem_len_t      dcache_uc_read_len_i,
  input  mem_size_t     dcache_uc_read_size_i,
  input  mem_id_t       dcache_uc_read_id_i,
  output logic          dcache_uc_read_resp_valid_o,
  input  logic          dcache_uc_read_resp_ready_i,
  output mem_data_t     dcache_uc_read_resp_data_o,
  output mem_id_t       dcache_uc_read_resp_id_o,
  output logic          dcache_uc_read_resp_last_o,
  // Memory read request
  output logic          mem_req_valid_o,
  input  logic          mem_req_ready_i,
  output mem_addr_t     mem_req_addr_o,
  output mem_len_t      mem_req_len_o,
  output mem_size_t     mem_req_size_o,
  output mem_id_t       mem_req_id_o,
  // Memory read response
  input  logic          mem_resp_valid_i,
  output logic          mem_resp_ready_o,
  input  mem_data_t     mem_resp_data_i,
  input  mem_id_t       mem_resp_id_i,
  input  logic          mem_resp_last_i
);

  logic [N_READ_PORTS-1:0] arb_valid;
  logic [N_READ_PORTS-1:0] arb_ready;
  mem_addr_t               arb_addr [N_READ_PORTS];
  mem_len_t                arb_len  [N_READ_PORTS];
  mem_size_t               arb_size [N_READ_PORTS];
  mem_id_t                 arb_id   [N_READ_PORTS];
  logic [N_READ_PORTS-1:0] resp_valid;

  icache_miss_port u_icache_miss_port (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .miss_valid_i   (icache_miss_valid_i),
    .miss_ready_o   (icache_miss_ready_o),
    .miss_paddr_i   (icache_miss_paddr_i),
    .miss_id_i      (icache_miss_id_i),
    .req_valid_o    (arb_valid[PORT_ICACHE]),
    .req_ready_i    (arb_ready[PORT_ICACHE]),
    .req_addr_o     (arb_addr[PORT_ICACHE]),
    .req_len_o      (arb_len[PORT_ICACHE]),
    .req_size_o     (arb_size[PORT_ICACHE]),
    .req_id_o       (arb_id[PORT_ICACHE]),
    .refill_valid_i (resp_valid[PORT_ICACHE]),
    .refill_data_i  (mem_resp_data_i),
    .refill_last_i  (mem_resp_last_i),
    .line_valid_o   (icache_miss_resp_valid_o),
    .line_data_o    (icache_miss_resp_data_o)
  );

  // Data cache requesters go straight to the arbiter
  assign arb_valid[PORT_DCACHE]   = dcache_miss_valid_i;
  assign arb_addr[PORT_DCACHE]    = dcache_miss_addr_i;
  assign arb_len[PORT_DCACHE]     = dcache_miss_len_i;
  assign arb_size[PORT_DCACHE]    = dcache_miss_size_i;
  assign arb_id[PORT_DCACHE]      = dcache_miss_id_i;
  assign dcache_miss_ready_o      = arb_ready[PORT_DCACHE];

  assign arb_valid[PORT_UNCACHED] = dcache_uc_read_valid_i;
  assign arb_addr[PORT_UNCACHED]  = dcache_uc_read_addr_i;
  assign arb_len[PORT_UNCACHED]   = dcache_uc_read_len_i;
  assign arb_size[PORT_UNCACHED]  = dcache_uc_read_size_i;
  assign arb_id[PORT_UNCACHED]    = dcache_uc_read_id_i;
  assign dcache_uc_read_ready_o   = arb_ready[PORT_UNCACHED];

  read_req_arbiter u_read_req_arbiter (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .req_valid_i     (arb_valid),
    .req_ready_o     (arb_ready),
    .req_addr_i      (arb_addr),
    .req_len_i       (arb_len),
    .req_size_i      (arb_size),
    .req_id_i        (arb_id),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_len_o   (mem_req_len_o),
    .mem_req_size_o  (mem_req_size_o),
    .mem_req_id_o    (mem_req_id_o)
  );

  read_resp_demux u_read_resp_demux (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .icache_id_i      (icache_miss_id_i),
    .uncached_id_i    (dcache_uc_read_id_i),
    .mem_resp_valid_i (mem_resp_valid_i),
    .mem_resp_ready_o (mem_resp_ready_o),
    .mem_resp_id_i    (mem_resp_id_i),
    .resp_valid_o     (resp_valid),
    .resp_ready_i     ({dcache_uc_read_resp_ready_i, dcache_miss_resp_ready_i})
  );

  // Response payload fans out to both data cache ports
  assign dcache_miss_resp_valid_o    = resp_valid[PORT_DCACHE];
  assign dcache_miss_resp_data_o     = mem_resp_data_i;
  assign dcache_miss_resp_id_o       = mem_resp_id_i;
  assign dcache_miss_resp_last_o     = mem_resp_last_i;
  assign dcache_uc_read_resp_valid_o = resp_valid[PORT_UNCACHED];
  assign dcache_uc_read_resp_data_o  = mem_resp_data_i;
  assign dcache_uc_read_resp_id_o    = mem_resp_id_i;
  assign dcache_uc_read_resp_last_o  = mem_resp_last_i;

endmodule

/* verilog/icache_miss_port.sv */
// Instruction cache miss request slot and refill beat gathering into a cache line
`timescale 1ns/1ns

module icache_miss_port import cache_mem_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_n_i,
  // Miss request from the instruction cache
  input  logic          miss_valid_i,
  output logic          miss_ready_o,
  input  icache_paddr_t miss_paddr_i,
  input  mem_id_t       miss_id_i,
  // Read request towards the arbiter
  output logic          req_valid_o,
  input  logic          req_ready_i,
  output mem_addr_t     req_addr_o,
  output mem_len_t      req_len_o,
  output mem_size_t     req_size_o,
  output mem_id_t       req_id_o,
  // Refill beats, always accepted
  input  logic          refill_valid_i,
  input  mem_data_t     refill_data_i,
  input  logic          refill_last_i,
  // Assembled line
  output logic          line_valid_o,
  output icache_line_t  line_data_o
);

  logic                            slot_valid_q;
  icache_paddr_t                   slot_paddr_q;
  mem_id_t                         slot_id_q;
  logic                            slot_load;
  logic [$clog2(ICACHE_BEATS)-1:0] beat_q;
  icache_line_t                    line_q;
  logic                            line_valid_q;

  // The slot absorbs a valid that the cache may withdraw
  assign miss_ready_o = ~slot_valid_q;
  assign slot_load    = miss_valid_i & miss_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      slot_valid_q <= 1'b0;
    end else if (slot_load) begin
      slot_valid_q <= 1'b1;
    end else if (req_ready_i) begin
      slot_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (slot_load) begin
      slot_paddr_q <= miss_paddr_i;
      slot_id_q    <= miss_id_i;
    end
  end

  // Fixed length line read, physical address zero extended
  assign req_valid_o = slot_valid_q;
  assign req_addr_o  = {{(MEM_ADDR_W - ICACHE_PADDR_W){1'b0}}, slot_paddr_q};
  assign req_len_o   = ICACHE_REQ_LEN;
  assign req_size_o  = ICACHE_REQ_SIZE;
  assign req_id_o    = slot_id_q;

  // Beat counter wraps on the last beat of a line
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      beat_q       <= '0;
      line_valid_q <= 1'b0;
    end else begin
      line_valid_q <= refill_valid_i & refill_last_i;
      if (refill_valid_i) begin
        beat_q <= refill_last_i ? '0 : beat_q + 1'b1;
      end
    end
  end

  // Beats fill the line from the low half upward
  always_ff @(posedge clk_i) begin
    if (refill_valid_i) begin
      line_q[beat_q*MEM_DATA_W +: MEM_DATA_W] <= refill_data_i;
    end
  end

  assign line_valid_o = line_valid_q;
  assign line_data_o  = line_q;

  // Next line must not start while the previous one is presented
  a_no_beat_during_line: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    refill_valid_i |-> !line_valid_o);

  // Memory returns exactly one line worth of beats
  a_last_on_final_beat: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    refill_valid_i && refill_last_i |-> beat_q == (ICACHE_BEATS - 1));

endmodule

/* verilog/read_req_arbiter.sv */
// Round-robin arbiter of the read requesters onto one registered memory request
`timescale 1ns/1ns

module read_req_arbiter import cache_mem_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Requesters
  input  logic [N_READ_PORTS-1:0] req_valid_i,
  output logic [N_READ_PORTS-1:0] req_ready_o,
  input  mem_addr_t               req_addr_i [N_READ_PORTS],
  input  mem_len_t                req_len_i  [N_READ_PORTS],
  input  mem_size_t               req_size_i [N_READ_PORTS],
  input  mem_id_t                 req_id_i   [N_READ_PORTS],
  // Memory request
  output logic                    mem_req_valid_o,
  input  logic                    mem_req_ready_i,
  output mem_addr_t               mem_req_addr_o,
  output mem_len_t                mem_req_len_o,
  output mem_size_t               mem_req_size_o,
  output mem_id_t                 mem_req_id_o
);

  port_idx_t last_q;
  port_idx_t grant_idx;
  logic      grant_any;
  logic      load_ok;
  logic      grant_fire;
  logic      out_valid_q;

  // Register is free when empty or draining this cycle
  assign load_ok    = ~out_valid_q | mem_req_ready_i;
  assign grant_fire = load_ok & grant_any;

  // First valid port after the last winner
  always_comb begin
    int idx;
    grant_any = 1'b0;
    grant_idx = last_q;
    for (int off = 1; off <= N_READ_PORTS; off++) begin
      idx = int'(last_q) + off;
      if (idx >= N_READ_PORTS) begin
        idx = idx - N_READ_PORTS;
      end
      if (!grant_any && req_valid_i[idx]) begin
        grant_any = 1'b1;
        grant_idx = port_idx_t'(idx);
      end
    end
  end

  always_comb begin
    req_ready_o = '0;
    if (grant_fire) begin
      req_ready_o[grant_idx] = 1'b1;
    end
  end

  // Reset pointer so the icache port wins first
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
      last_q      <= port_idx_t'(N_READ_PORTS - 1);
    end else if (grant_fire) begin
      out_valid_q <= 1'b1;
      last_q      <= grant_idx;
    end else if (mem_req_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant_fire) begin
      mem_req_addr_o <= req_addr_i[grant_idx];
      mem_req_len_o  <= req_len_i[grant_idx];
      mem_req_size_o <= req_size_i[grant_idx];
      mem_req_id_o   <= req_id_i[grant_idx];
    end
  end

  assign mem_req_valid_o = out_valid_q;

  // Held request stays put until memory takes it
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_addr_o)
      && $stable(mem_req_len_o) && $stable(mem_req_size_o) && $stable(mem_req_id_o));

endmodule

/* verilog/read_resp_demux.sv */
// Memory read response routing to a requester port by transaction id
`timescale 1ns/1ns

module read_resp_demux import cache_mem_pkg::*; (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  // Route ids
  input  mem_id_t                          icache_id_i,
  input  mem_id_t                          uncached_id_i,
  // Memory response
  input  logic                             mem_resp_valid_i,
  output logic                             mem_resp_ready_o,
  input  mem_id_t                          mem_resp_id_i,
  // Per-port handshake, the icache port has no ready
  output logic [N_READ_PORTS-1:0]          resp_valid_o,
  input  logic [PORT_UNCACHED:PORT_DCACHE] resp_ready_i
);

  port_idx_t route_port;

  // Icache id takes priority, dcache takes everything unmatched
  always_comb begin
    if (mem_resp_id_i == icache_id_i) begin
      route_port = PORT_ICACHE;
    end else if (mem_resp_id_i == uncached_id_i) begin
      route_port = PORT_UNCACHED;
    end else begin
      route_port = PORT_DCACHE;
    end
  end

  always_comb begin
    resp_valid_o = '0;
    resp_valid_o[route_port] = mem_resp_valid_i;
  end

  // Line gathering never stalls
  always_comb begin
    case (route_port)
      PORT_DCACHE:   mem_resp_ready_o = resp_ready_i[PORT_DCACHE];
      PORT_UNCACHED: mem_resp_ready_o = resp_ready_i[PORT_UNCACHED];
      default:       mem_resp_ready_o = 1'b1;
    endcase
  end

  // Identical route ids would hide uncached responses behind the icache
  a_route_ids_differ: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_resp_valid_i |-> icache_id_i != uncached_id_i);

endmodule
